/* filelist.f */
mipsPkg.sv
pipeBus.sv
fetchUnit.sv
decodeUnit.sv
regFile.sv
executeStage.sv
hazardUnit.sv
mipsCore.sv
mipsCore_assertions.sv
tb_mipsCore.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
    --top-module tb_mipsCore -f filelist.f -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -qx "=== PASS ===" sim.log; then
    exit 0
fi
exit 1

/* tb_mipsCore.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mipsCore import mipsPkg::*; ();

    localparam int numBlocks = 40;   // 16-byte blocks, first two hold the prologue
    localparam int imemWords = 1024;
    localparam int dmemWords = 64;
    localparam logic [31:0] endAddr = 32'(numBlocks * 16);

    typedef struct packed {
        logic [31:0] pc;
        logic        writes;
        logic [4:0]  dest;
        logic [31:0] value;
        logic        isStore;
    } commit_t;

    logic        clk;
    logic        rstN;
    logic [31:0] instrAddr;
    logic [31:0] instrWord;
    logic [31:0] dataAddr;
    logic [31:0] dataRdata;
    logic [31:0] dataWdata;
    logic        dataWen;
    logic [31:0] debugWbPc;
    logic        debugWbRfWen;
    logic [4:0]  debugWbRfWnum;
    logic [31:0] debugWbRfWdata;
    logic        debugCommit;

    logic [31:0] imem [imemWords];
    logic [31:0] dmem [dmemWords];
    logic [31:0] refMem [dmemWords];
    logic [31:0] refRegs [32];
    commit_t     expQ [$];
    logic [15:0] lfsr;
    logic        progReady = 1'b0;
    int          progLen;
    int          totalCommits;
    int          checkedCount;
    int          storesDone;
    int          wenSeen;
    int          errorCount;

    mipsCore dut (
        .clk_i            (clk),
        .rstN_i           (rstN),
        .instr_i          (instrWord),
        .dataRdata_i      (dataRdata),
        .instrAddr_o      (instrAddr),
        .dataAddr_o       (dataAddr),
        .dataWdata_o      (dataWdata),
        .dataWen_o        (dataWen),
        .debugWbPc_o      (debugWbPc),
        .debugWbRfWen_o   (debugWbRfWen),
        .debugWbRfWnum_o  (debugWbRfWnum),
        .debugWbRfWdata_o (debugWbRfWdata),
        .debugCommit_o    (debugCommit)
    );

    bind mipsCore mipsCore_assertions checks (
        .clk_i           (clk_i),
        .rstN_i          (rstN_i),
        .stall_i         (stall),
        .dataWen_i       (dataWen_o),
        .debugCommit_i   (debugCommit_o),
        .debugWbRfWen_i  (debugWbRfWen_o),
        .debugWbRfWnum_i (debugWbRfWnum_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // combinational read ports, stores land on the clock edge
    assign instrWord = imem[instrAddr[11:2]];
    assign dataRdata = dmem[dataAddr[7:2]];

    always @(posedge clk) begin
        if (dataWen) begin
            dmem[dataAddr[7:2]] <= dataWdata;
        end
    end

    // 16-bit Galois LFSR, one step per bit
    function automatic logic [31:0] rnd(input int nBits);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < nBits; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 16'hB400 : 16'h0000);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return addr * 32'h9E37_79B1 + 32'h1357_2468;
    endfunction

    function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sh);
        return {opSpecial, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // ALU or memory op on $0..$7, loads and stores based on $0 or $8
    function automatic logic [31:0] randomAluOp();
        logic [3:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  base;
        logic [15:0] imm;
        logic [15:0] offs;
        logic [31:0] word;
        kind = 4'(rnd(4));
        rs   = 5'(rnd(3));
        rt   = 5'(rnd(3));
        rd   = 5'(rnd(3));
        imm  = 16'(rnd(16));
        base = (rnd(1) == 32'd1) ? 5'd8 : 5'd0;
        offs = {10'b0, imm[3:0], 2'b00};
        case (kind)
            4'd0:        word = encR(fnAddu, rs, rt, rd, 5'd0);
            4'd1:        word = encR(fnSubu, rs, rt, rd, 5'd0);
            4'd2:        word = encR(fnAnd, rs, rt, rd, 5'd0);
            4'd3:        word = encR(fnOr, rs, rt, rd, 5'd0);
            4'd4:        word = encR(fnXor, rs, rt, rd, 5'd0);
            4'd5:        word = encR(fnSlt, rs, rt, rd, 5'd0);
            4'd6:        word = encR(fnSll, 5'd0, rt, rd, imm[4:0]);
            4'd8:        word = encI(opAndi, rs, rd, imm);
            4'd9:        word = encI(opOri, rs, rd, imm);
            4'd10:       word = encI(opLui, 5'd0, rd, imm);
            4'd11, 4'd12: word = encI(opLw, base, rd, offs);
            4'd13, 4'd14: word = encI(opSw, base, rt, offs);
            default:     word = encI(opAddiu, rs, rd, imm);
        endcase
        return word;
    endfunction

    // prologue, then blocks of ALU ops, branches, J and JR, all jumping forward
    task automatic buildProgram();
        int          pos;
        int          tgt;
        logic [2:0]  kind;
        logic [31:0] tgtAddr;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [5:0]  brOp;
        for (int i = 0; i < imemWords; i++) begin
            imem[i] = 32'h0;   // nop padding
        end
        for (int r = 1; r < 8; r++) begin
            imem[r-1] = encI(opAddiu, 5'd0, 5'(r), 16'(rnd(16)));
        end
        imem[7] = encI(opAddiu, 5'd0, 5'd8, 16'd32);   // second load/store base
        for (int b = 2; b < numBlocks; b++) begin
            pos  = b * 4;
            kind = 3'(rnd(3));
            tgt  = b + 1 + int'(rnd(2));
            if (tgt > numBlocks) begin
                tgt = numBlocks;
            end
            tgtAddr = 32'(tgt * 16);
            for (int k = 0; k < 4; k++) begin
                imem[pos+k] = randomAluOp();
            end
            if (kind == 3'd4 || kind == 3'd5) begin
                ra   = 5'(rnd(3));
                rb   = (rnd(1) == 32'd1) ? ra : 5'(rnd(3));
                brOp = (rnd(1) == 32'd1) ? opBeq : opBne;
                imem[pos] = encI(brOp, ra, rb, 16'((tgtAddr - 32'(pos * 4 + 4)) >> 2));
            end else if (kind == 3'd6) begin
                imem[pos] = {opJ, tgtAddr[27:2]};
            end else if (kind == 3'd7) begin
                imem[pos]   = encI(opAddiu, 5'd0, 5'd9, tgtAddr[15:0]);
                imem[pos+1] = encR(fnJr, 5'd9, 5'd0, 5'd0, 5'd0);
            end
        end
        progLen = numBlocks * 4;
    endtask

    // ISA-level interpreter with one delay slot, queues every commit
    function automatic void runReference();
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nnpc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] res;
        commit_t     c;
        int          steps;
        pc    = resetPc;
        npc   = resetPc + 32'd4;
        steps = 0;
        while (pc != endAddr && steps < 10000) begin
            ins  = imem[pc[11:2]];
            a    = refRegs[ins[25:21]];
            b    = refRegs[ins[20:16]];
            imm  = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            nnpc = npc + 32'd4;
            res  = '0;
            c    = '0;
            c.pc   = pc;
            c.dest = ins[20:16];
            case (ins[31:26])
                opSpecial: begin
                    c.writes = 1'b1;
                    c.dest   = ins[15:11];
                    case (ins[5:0])
                        fnAddu: res = a + b;
                        fnSubu: res = a - b;
                        fnAnd:  res = a & b;
                        fnOr:   res = a | b;
                        fnXor:  res = a ^ b;
                        fnSlt:  res = {31'b0, $signed(a) < $signed(b)};
                        fnSll:  res = b << ins[10:6];
                        fnJr: begin
                            c.writes = 1'b0;
                            nnpc     = a;
                        end
                        default: c.writes = 1'b0;
                    endcase
                end
                opAddiu: begin
                    c.writes = 1'b1;
                    res      = a + imm;
                end
                opAndi: begin
                    c.writes = 1'b1;
                    res      = a & {16'b0, ins[15:0]};
                end
                opOri: begin
                    c.writes = 1'b1;
                    res      = a | {16'b0, ins[15:0]};
                end
                opLui: begin
                    c.writes = 1'b1;
                    res      = {ins[15:0], 16'b0};
                end
                opLw: begin
                    c.writes = 1'b1;
                    res      = refMem[addr[7:2]];
                end
                opSw: begin
                    c.isStore          = 1'b1;
                    refMem[addr[7:2]] = b;
                end
                opBeq: if (a == b) nnpc = pc + 32'd4 + (imm << 2);
                opBne: if (a != b) nnpc = pc + 32'd4 + (imm << 2);
                opJ:   nnpc = {npc[31:28], ins[25:0], 2'b00};
                default: ;
            endcase
            c.value = res;
            if (c.writes && c.dest != 5'd0) begin
                refRegs[c.dest] = res;
            end
            expQ.push_back(c);
            pc    = npc;
            npc   = nnpc;
            steps = steps + 1;
        end
    endfunction

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "check %s failed", name);
        end
    endtask

    // compare process, sampled away from the rising edge
    always @(negedge clk) begin : compareCommits
        commit_t e;
        if (rstN && debugCommit && expQ.size() > 0) begin
            e = expQ.pop_front();
            checkEq($sformatf("commit %0d pc", checkedCount), e.pc, debugWbPc);
            checkEq($sformatf("commit %0d rf wen", checkedCount),
                    {31'b0, e.writes && e.dest != 5'd0}, {31'b0, debugWbRfWen});
            if (e.writes) begin
                checkEq($sformatf("commit %0d rf wnum", checkedCount),
                        {27'b0, e.dest}, {27'b0, debugWbRfWnum});
            end
            if (e.writes && e.dest != 5'd0) begin
                checkEq($sformatf("commit %0d rf wdata", checkedCount),
                        e.value, debugWbRfWdata);
            end
            if (e.isStore) begin
                storesDone++;
            end
            checkedCount++;
        end
        // each data write belongs to the next store about to commit
        if (dataWen) begin
            wenSeen++;
            checkEq("data write order", storesDone + 1, wenSeen);
        end
    end

    initial begin
        rstN         <= 1'b0;
        lfsr         = 16'd44990;
        checkedCount = 0;
        storesDone   = 0;
        wenSeen      = 0;
        errorCount   = 0;
        for (int i = 0; i < dmemWords; i++) begin
            dmem[i]   = fillWord(32'(i) << 2);
            refMem[i] = dmem[i];
        end
        for (int r = 0; r < 32; r++) begin
            refRegs[r] = '0;
        end
        buildProgram();
        runReference();
        totalCommits = expQ.size();
        progReady    = 1'b1;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        wait (checkedCount == totalCommits);
        @(negedge clk);
        for (int i = 0; i < dmemWords; i++) begin
            checkEq($sformatf("final dmem word %0d", i), refMem[i], dmem[i]);
        end
        if (errorCount == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "%0d checks failed", errorCount);
        end
    end

    // worst case every instruction stalls once, plus pipeline fill
    initial begin
        wait (progReady);
        repeat (6 * progLen + 50) @(posedge clk);
        $display("watchdog expired with %0d of %0d commits seen", checkedCount, totalCommits);
        $display("=== FAIL ===");
        $fatal(1, "simulation timed out");
    end

endmodule

`default_nettype wire

/* mipsCore_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module mipsCore_assertions import mipsPkg::*; (
    input wire                clk_i,
    input wire                rstN_i,
    input wire                stall_i,
    input wire                dataWen_i,
    input wire                debugCommit_i,
    input wire                debugWbRfWen_i,
    input wire [regAddrW-1:0] debugWbRfWnum_i
);

    logic [1:0] cyclesOut;   // cycles since reset release, saturates at 3

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            cyclesOut <= 2'd0;
        end else if (cyclesOut != 2'd3) begin
            cyclesOut <= cyclesOut + 2'd1;
        end
    end

    resetQuiet: assert property (@(posedge clk_i)
        !rstN_i |=> (!debugCommit_i && !dataWen_i))
        else $error("commit or data write while in reset");

    // nothing reaches memory or writeback in the first cycles out of reset
    earlyQuiet: assert property (@(posedge clk_i)
        (rstN_i && cyclesOut != 2'd3) |-> (!debugCommit_i && !dataWen_i))
        else $error("commit or data write too soon after reset");

    singleStall: assert property (@(posedge clk_i) disable iff (!rstN_i)
        stall_i |=> !stall_i)
        else $error("stall held for more than one cycle");

    // a reported register write belongs to a real commit, never to $0
    zeroNeverWritten: assert property (@(posedge clk_i) disable iff (!rstN_i)
        debugWbRfWen_i |-> (debugCommit_i && debugWbRfWnum_i != '0))
        else $error("register write reported without a commit or to register zero");

endmodule

`default_nettype wire

/* mipsCore.sv */
`timescale 1ns/10ps
`default_nettype none

module mipsCore import mipsPkg::*; (
    input  wire                 clk_i,
    input  wire                 rstN_i,
    input  wire [xlen-1:0]      instr_i,
    input  wire [xlen-1:0]      dataRdata_i,
    output logic [xlen-1:0]     instrAddr_o,
    output logic [xlen-1:0]     dataAddr_o,
    output logic [xlen-1:0]     dataWdata_o,
    output logic                dataWen_o,
    output logic [xlen-1:0]     debugWbPc_o,
    output logic                debugWbRfWen_o,
    output logic [regAddrW-1:0] debugWbRfWnum_o,
    output logic [xlen-1:0]     debugWbRfWdata_o,
    output logic                debugCommit_o
);

    logic [xlen-1:0]     pcPlus4F;
    logic                stall;
    logic                redirect;
    logic [xlen-1:0]     target;
    logic [regAddrW-1:0] rsAddr;
    logic [regAddrW-1:0] rtAddr;
    logic [xlen-1:0]     rdA;
    logic [xlen-1:0]     rdB;
    logic [1:0]          fwdA;
    logic [1:0]          fwdB;
    logic [xlen-1:0]     memAddr;
    logic [xlen-1:0]     pcE;

    // memory stage register
    logic                regWriteM;
    logic [regAddrW-1:0] writeRegM;
    logic                isLoadM;
    logic                validM;
    logic [xlen-1:0]     pcM;

    // writeback stage register
    logic                regWriteW;
    logic [regAddrW-1:0] writeRegW;
    logic                validW;
    logic [xlen-1:0]     valueW;
    logic [xlen-1:0]     pcW;

    decodeExBus deBus ();
    stageBus    busE ();
    stageBus    busM ();
    stageBus    busW ();

    fetchUnit uFetch (
        .clk_i      (clk_i),
        .rstN_i     (rstN_i),
        .stall_i    (stall),
        .redirect_i (redirect),
        .target_i   (target),
        .pc_o       (instrAddr_o),
        .pcPlus4_o  (pcPlus4F)
    );

    decodeUnit uDecode (
        .clk_i      (clk_i),
        .rstN_i     (rstN_i),
        .stall_i    (stall),
        .instr_i    (instr_i),
        .pcPlus4_i  (pcPlus4F),
        .fwdA_i     (fwdA),
        .fwdB_i     (fwdB),
        .rdA_i      (rdA),
        .rdB_i      (rdB),
        .busE       (busE),
        .busM       (busM),
        .busW       (busW),
        .exOut      (deBus),
        .rsAddr_o   (rsAddr),
        .rtAddr_o   (rtAddr),
        .redirect_o (redirect),
        .target_o   (target)
    );

    regFile uRegs (
        .clk_i    (clk_i),
        .rsAddr_i (rsAddr),
        .rtAddr_i (rtAddr),
        .wb       (busW),
        .rdA_o    (rdA),
        .rdB_o    (rdB)
    );

    executeStage uExec (
        .clk_i       (clk_i),
        .rstN_i      (rstN_i),
        .exIn        (deBus),
        .exBus       (busE),
        .memAddr_o   (memAddr),
        .storeData_o (dataWdata_o),
        .memWrite_o  (dataWen_o),
        .pcE_o       (pcE)
    );

    hazardUnit uHazard (
        .rs_i    (rsAddr),
        .rt_i    (rtAddr),
        .busE    (busE),
        .busM    (busM),
        .busW    (busW),
        .fwdA_o  (fwdA),
        .fwdB_o  (fwdB),
        .stall_o (stall)
    );

    assign dataAddr_o = memAddr;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            regWriteM <= 1'b0;
            isLoadM   <= 1'b0;
            validM    <= 1'b0;
            regWriteW <= 1'b0;
            validW    <= 1'b0;
        end else begin
            regWriteM <= busE.regWrite;
            isLoadM   <= busE.isLoad;
            validM    <= deBus.valid;
            regWriteW <= busM.regWrite;
            validW    <= validM;
        end
    end

    always_ff @(posedge clk_i) begin
        writeRegM <= busE.writeReg;
        pcM       <= pcE;
        writeRegW <= busM.writeReg;
        valueW    <= busM.value;
        pcW       <= pcM;
    end

    // read data comes back in the memory cycle
    assign busM.regWrite = regWriteM;
    assign busM.writeReg = writeRegM;
    assign busM.value    = isLoadM ? dataRdata_i : memAddr;
    assign busM.isLoad   = isLoadM;

    assign busW.regWrite = regWriteW;
    assign busW.writeReg = writeRegW;
    assign busW.value    = valueW;
    assign busW.isLoad   = 1'b0;   // load data already settled in valueW

    assign debugWbPc_o      = pcW;
    assign debugWbRfWen_o   = regWriteW && (writeRegW != '0);   // $0 commits without a write
    assign debugWbRfWnum_o  = writeRegW;
    assign debugWbRfWdata_o = valueW;
    assign debugCommit_o    = validW;

endmodule

`default_nettype wire

/* hazardUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazardUnit import mipsPkg::*; (
    input  wire [regAddrW-1:0] rs_i,
    input  wire [regAddrW-1:0] rt_i,
    stageBus.consumer          busE,
    stageBus.consumer          busM,
    stageBus.consumer          busW,
    output logic [1:0]         fwdA_o,
    output logic [1:0]         fwdB_o,
    output logic               stall_o
);

    // youngest stage wins
    function automatic logic [1:0] pickSrc(input logic [regAddrW-1:0] r);
        if (r == '0)
            return fwdReg;
        if (busE.regWrite && busE.writeReg == r)
            return fwdExec;
        if (busM.regWrite && busM.writeReg == r)
            return fwdMem;
        if (busW.regWrite && busW.writeReg == r)
            return fwdWb;
        return fwdReg;
    endfunction

    always_comb begin
        fwdA_o = pickSrc(rs_i);
        fwdB_o = pickSrc(rt_i);
    end

    // load data only exists from the memory stage on
    assign stall_o = busE.isLoad && (fwdA_o == fwdExec || fwdB_o == fwdExec);

endmodule

`default_nettype wire

/* executeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module executeStage import mipsPkg::*; (
    input  wire             clk_i,
    input  wire             rstN_i,
    decodeExBus.sink        exIn,
    stageBus.producer       exBus,
    output logic [xlen-1:0] memAddr_o,
    output logic [xlen-1:0] storeData_o,
    output logic            memWrite_o,
    output logic [xlen-1:0] pcE_o
);

    logic [xlen-1:0] aluRes;

    always_comb begin
        case (exIn.aluOp)
            aluAdd:  aluRes = exIn.opA + exIn.opB;
            aluSub:  aluRes = exIn.opA - exIn.opB;
            aluAnd:  aluRes = exIn.opA & exIn.opB;
            aluOr:   aluRes = exIn.opA | exIn.opB;
            aluXor:  aluRes = exIn.opA ^ exIn.opB;
            aluSlt:  aluRes = {{(xlen-1){1'b0}}, $signed(exIn.opA) < $signed(exIn.opB)};
            aluSll:  aluRes = exIn.opA << exIn.opB[4:0];   // shamt rides in opB
            aluLui:  aluRes = {exIn.opB[15:0], 16'b0};
            default: aluRes = '0;
        endcase
    end

    // pending write for forwarding, loads flagged for the stall check
    assign exBus.regWrite = exIn.regWrite;
    assign exBus.writeReg = exIn.writeReg;
    assign exBus.value    = aluRes;
    assign exBus.isLoad   = exIn.memRead;

    assign pcE_o = exIn.pc;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            memWrite_o <= 1'b0;
        end else begin
            memWrite_o <= exIn.memWrite;
        end
    end

    always_ff @(posedge clk_i) begin
        memAddr_o   <= aluRes;   // also the alu result seen in memory
        storeData_o <= exIn.storeData;
    end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile import mipsPkg::*; (
    input  wire                 clk_i,
    input  wire [regAddrW-1:0]  rsAddr_i,
    input  wire [regAddrW-1:0]  rtAddr_i,
    stageBus.consumer           wb,
    output logic [xlen-1:0]     rdA_o,
    output logic [xlen-1:0]     rdB_o
);

    logic [xlen-1:0] regs [2**regAddrW];

    // written at the end of the writeback cycle
    always_ff @(posedge clk_i) begin
        if (wb.regWrite) begin
            regs[wb.writeReg] <= wb.value;
        end
    end

    // $0 reads zero whatever was written there
    assign rdA_o = (rsAddr_i == '0) ? '0 : regs[rsAddr_i];
    assign rdB_o = (rtAddr_i == '0) ? '0 : regs[rtAddr_i];

endmodule

`default_nettype wire

/* decodeUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeUnit import mipsPkg::*; (
    input  wire                 clk_i,
    input  wire                 rstN_i,
    input  wire                 stall_i,
    input  wire instrWord_u     instr_i,
    input  wire [xlen-1:0]      pcPlus4_i,
    input  wire [1:0]           fwdA_i,
    input  wire [1:0]           fwdB_i,
    input  wire [xlen-1:0]      rdA_i,
    input  wire [xlen-1:0]      rdB_i,
    stageBus.consumer           busE,
    stageBus.consumer           busM,
    stageBus.consumer           busW,
    decodeExBus.source          exOut,
    output logic [regAddrW-1:0] rsAddr_o,
    output logic [regAddrW-1:0] rtAddr_o,
    output logic                redirect_o,
    output logic [xlen-1:0]     target_o
);

    instrWord_u        instrD;
    logic [xlen-1:0]   pcPlus4D;
    logic              validD;

    logic [aluOpW-1:0] aluOp;
    logic              regWrite;
    logic              memRead;
    logic              memWrite;
    logic              useImm;
    logic              zeroExt;
    logic              isSll;
    logic              useRd;
    logic              isBeq;
    logic              isBne;
    logic              isJ;
    logic              isJr;
    logic [xlen-1:0]   imm;
    logic [xlen-1:0]   srcA;
    logic [xlen-1:0]   srcB;
    logic              taken;

    // fetch/decode register, frozen by a stall
    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            instrD <= '0;   // reads as sll $0
            validD <= 1'b0;
        end else if (!stall_i) begin
            instrD <= instr_i;
            validD <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            pcPlus4D <= pcPlus4_i;
        end
    end

    assign rsAddr_o = instrD.rView.rs;
    assign rtAddr_o = instrD.rView.rt;

    always_comb begin
        aluOp    = aluAdd;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        useImm   = 1'b1;
        zeroExt  = 1'b0;
        isSll    = 1'b0;
        useRd    = 1'b0;
        isBeq    = 1'b0;
        isBne    = 1'b0;
        isJ      = 1'b0;
        isJr     = 1'b0;
        case (instrD.rView.op)
            opSpecial: begin
                useImm   = 1'b0;
                useRd    = 1'b1;
                regWrite = 1'b1;
                case (instrD.rView.funct)
                    fnAddu: aluOp = aluAdd;
                    fnSubu: aluOp = aluSub;
                    fnAnd:  aluOp = aluAnd;
                    fnOr:   aluOp = aluOr;
                    fnXor:  aluOp = aluXor;
                    fnSlt:  aluOp = aluSlt;
                    fnSll: begin
                        aluOp = aluSll;
                        isSll = 1'b1;
                    end
                    fnJr: begin
                        regWrite = 1'b0;
                        isJr     = 1'b1;
                    end
                    default: regWrite = 1'b0;   // unsupported funct acts as nop
                endcase
            end
            opAddiu: regWrite = 1'b1;
            opAndi: begin
                aluOp    = aluAnd;
                zeroExt  = 1'b1;
                regWrite = 1'b1;
            end
            opOri: begin
                aluOp    = aluOr;
                zeroExt  = 1'b1;
                regWrite = 1'b1;
            end
            opLui: begin
                aluOp    = aluLui;
                zeroExt  = 1'b1;
                regWrite = 1'b1;
            end
            opLw: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            opSw:  memWrite = 1'b1;
            opBeq: isBeq = 1'b1;
            opBne: isBne = 1'b1;
            opJ:   isJ = 1'b1;
            default: ;
        endcase
    end

    assign imm = zeroExt ? {16'b0, instrD.iView.imm}
                         : {{16{instrD.iView.imm[15]}}, instrD.iView.imm};

    // forwarded operands, also used by the branch compare
    always_comb begin
        case (fwdA_i)
            fwdExec: srcA = busE.value;
            fwdMem:  srcA = busM.value;
            fwdWb:   srcA = busW.value;
            default: srcA = rdA_i;
        endcase
        case (fwdB_i)
            fwdExec: srcB = busE.value;
            fwdMem:  srcB = busM.value;
            fwdWb:   srcB = busW.value;
            default: srcB = rdB_i;
        endcase
    end

    assign taken      = (isBeq && srcA == srcB) || (isBne && srcA != srcB);
    assign redirect_o = validD && (taken || isJ || isJr);

    always_comb begin
        if (isJr) begin
            target_o = srcA;
        end else if (isJ) begin
            target_o = {pcPlus4D[31:28], instrD.jView.target, 2'b00};
        end else begin
            target_o = pcPlus4D + {imm[29:0], 2'b00};   // branch offset
        end
    end

    // decode/execute register, bubble while stalled
    always_ff @(posedge clk_i) begin
        if (!rstN_i || stall_i || !validD) begin
            exOut.valid    <= 1'b0;
            exOut.regWrite <= 1'b0;
            exOut.memRead  <= 1'b0;
            exOut.memWrite <= 1'b0;
        end else begin
            exOut.valid    <= 1'b1;
            exOut.regWrite <= regWrite;
            exOut.memRead  <= memRead;
            exOut.memWrite <= memWrite;
        end
    end

    always_ff @(posedge clk_i) begin
        exOut.aluOp     <= aluOp;
        exOut.opA       <= isSll ? srcB : srcA;   // sll shifts rt
        exOut.opB       <= useImm ? imm
                         : isSll ? {{(xlen-5){1'b0}}, instrD.rView.shamt} : srcB;
        exOut.storeData <= srcB;
        exOut.writeReg  <= useRd ? instrD.rView.rd : instrD.iView.rt;
        exOut.pc        <= pcPlus4D - 32'd4;
    end

endmodule

`default_nettype wire

/* fetchUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchUnit import mipsPkg::*; (
    input  wire             clk_i,
    input  wire             rstN_i,
    input  wire             stall_i,
    input  wire             redirect_i,
    input  wire [xlen-1:0]  target_i,
    output logic [xlen-1:0] pc_o,
    output logic [xlen-1:0] pcPlus4_o
);

    logic [xlen-1:0] pcQ;

    assign pcPlus4_o = pcQ + 32'd4;
    assign pc_o      = pcQ;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            pcQ <= resetPc;
        end else if (!stall_i) begin
            // redirect comes from decode, one delay slot already fetched
            pcQ <= redirect_i ? target_i : pcPlus4_o;
        end
    end

endmodule

`default_nettype wire

/* pipeBus.sv */
`timescale 1ns/10ps
`default_nettype none

// contents of the decode/execute register
interface decodeExBus import mipsPkg::*; ();
    logic [aluOpW-1:0]   aluOp;
    logic [xlen-1:0]     opA;
    logic [xlen-1:0]     opB;
    logic [xlen-1:0]     storeData;   // rt value for SW
    logic [regAddrW-1:0] writeReg;
    logic                regWrite;
    logic                memRead;
    logic                memWrite;
    logic                valid;       // low for a bubble
    logic [xlen-1:0]     pc;

    modport source (
        output aluOp, opA, opB, storeData, writeReg,
        output regWrite, memRead, memWrite, valid, pc
    );
    modport sink (
        input aluOp, opA, opB, storeData, writeReg,
        input regWrite, memRead, memWrite, valid, pc
    );
endinterface

// one stage's pending register write, seen by forwarding
interface stageBus import mipsPkg::*; ();
    logic                regWrite;
    logic [regAddrW-1:0] writeReg;
    logic [xlen-1:0]     value;
    logic                isLoad;   // value not ready yet in execute

    modport producer (output regWrite, writeReg, value, isLoad);
    modport consumer (input regWrite, writeReg, value, isLoad);
endinterface

`default_nettype wire

/* mipsPkg.sv */
`default_nettype none

package mipsPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;
    localparam int aluOpW   = 4;
    localparam logic [xlen-1:0] resetPc = 32'h0000_0000;

    // major opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // function field of opSpecial
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;

    localparam logic [aluOpW-1:0] aluAdd = 4'd0;
    localparam logic [aluOpW-1:0] aluSub = 4'd1;
    localparam logic [aluOpW-1:0] aluAnd = 4'd2;
    localparam logic [aluOpW-1:0] aluOr  = 4'd3;
    localparam logic [aluOpW-1:0] aluXor = 4'd4;
    localparam logic [aluOpW-1:0] aluSlt = 4'd5;
    localparam logic [aluOpW-1:0] aluSll = 4'd6;
    localparam logic [aluOpW-1:0] aluLui = 4'd7;   // imm into upper half

    // where a decode operand is taken from
    localparam logic [1:0] fwdReg  = 2'd0;
    localparam logic [1:0] fwdExec = 2'd1;
    localparam logic [1:0] fwdMem  = 2'd2;
    localparam logic [1:0] fwdWb   = 2'd3;

    typedef struct packed {
        logic [5:0]          op;
        logic [regAddrW-1:0] rs;
        logic [regAddrW-1:0] rt;
        logic [regAddrW-1:0] rd;
        logic [4:0]          shamt;
        logic [5:0]          funct;
    } rFields_t;

    typedef struct packed {
        logic [5:0]          op;
        logic [regAddrW-1:0] rs;
        logic [regAddrW-1:0] rt;
        logic [15:0]         imm;
    } iFields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;   // word index inside the 256MB region
    } jFields_t;

    typedef union packed {
        rFields_t rView;
        iFields_t iView;
        jFields_t jView;
    } instrWord_u;

endpackage

`default_nettype wire
